// ==== hdl/io_pkg.sv ====
package io_pkg;

	typedef logic [2:0] io_size_t;    // 1, 2 or 4 bytes

	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [15:0] unused;
			logic [7:0]  syscfg_key;
			logic [7:0]  syscfg_value;
		} cmd;
	} io_data_u;

	typedef struct packed {
		logic [15:0] addr;
		logic        write;
		io_size_t    size;
		io_data_u    wdata;
	} io_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic        write;    // echoed from request
		logic        wide;     // came from a 32-bit device
	} io_resp_t;

	typedef struct packed {
		logic hdd0;
		logic hdd1;
		logic floppy;
		logic dma;
		logic pic;
		logic pit;
		logic ps2;
		logic rtc;
		logic sound;
		logic uart;
		logic vga;
		logic joy;
	} dev_sel_t;

	typedef struct packed {
		logic [31:0] hdd0;
		logic [31:0] hdd1;
		logic [7:0]  floppy;
		logic [7:0]  dma;
		logic [7:0]  pic;
		logic [7:0]  pit;
		logic [7:0]  ps2;
		logic [7:0]  rtc;
		logic [7:0]  sound;
		logic [7:0]  uart;
		logic [7:0]  vga;
		logic [7:0]  joy;
	} dev_rdata_t;

	typedef struct packed {
		logic [15:0] base;
		logic [3:0]  ign;    // low address bits ignored
	} port_range_t;

	localparam port_range_t PORT_HDD0       = '{16'h01F0, 4'd3};
	localparam port_range_t PORT_HDD0_ALT   = '{16'h03F6, 4'd0};
	localparam port_range_t PORT_HDD1       = '{16'h0170, 4'd3};
	localparam port_range_t PORT_HDD1_ALT   = '{16'h0376, 4'd0};
	localparam port_range_t PORT_FLOPPY     = '{16'h03F0, 4'd3};
	localparam port_range_t PORT_DMA_MASTER = '{16'h00C0, 4'd5};
	localparam port_range_t PORT_DMA_PAGE   = '{16'h0080, 4'd4};
	localparam port_range_t PORT_DMA_SLAVE  = '{16'h0000, 4'd4};
	localparam port_range_t PORT_PIC_MASTER = '{16'h0020, 4'd1};
	localparam port_range_t PORT_PIC_SLAVE  = '{16'h00A0, 4'd1};
	localparam port_range_t PORT_PIT        = '{16'h0040, 4'd2};
	localparam port_range_t PORT_PIT_ALT    = '{16'h0061, 4'd0};
	localparam port_range_t PORT_PS2_IO     = '{16'h0060, 4'd3};
	localparam port_range_t PORT_PS2_CTL    = '{16'h0090, 4'd4};
	localparam port_range_t PORT_RTC        = '{16'h0070, 4'd1};
	localparam port_range_t PORT_FM         = '{16'h0388, 4'd2};
	localparam port_range_t PORT_SB         = '{16'h0220, 4'd4};
	localparam port_range_t PORT_UART       = '{16'h03F8, 4'd3};
	localparam port_range_t PORT_MPU        = '{16'h0330, 4'd1};
	localparam port_range_t PORT_VGA_B      = '{16'h03B0, 4'd4};
	localparam port_range_t PORT_VGA_C      = '{16'h03C0, 4'd4};
	localparam port_range_t PORT_VGA_D      = '{16'h03D0, 4'd4};
	localparam port_range_t PORT_JOY        = '{16'h0201, 4'd0};

	localparam logic [15:0] SYSCFG_PORT   = 16'h8888;
	localparam logic [7:0]  SYSCFG_KEY    = 8'hA1;
	localparam logic [7:0]  SYSCFG_RESET  = 8'hA2;
	localparam logic [7:0]  UNMAPPED_BYTE = 8'hFF;

endpackage

// ==== hdl/io_req_queue.sv ====
`timescale 1ns/100ps

module io_req_queue import io_pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic    clk_sys,
	input  logic    reset,

	input  logic    req_valid,
	input  io_req_t req,
	output logic    req_credit,

	output logic    q_valid,
	output io_req_t q_head,
	input  logic    q_pop
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(QUEUE_DEPTH - 1);

	io_req_t          mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             pop;

	assign q_valid    = (count != '0);
	assign q_head     = mem[rd_ptr];
	assign pop        = q_pop & q_valid;
	assign req_credit = pop;    // freed entry goes straight back

	always_ff @(posedge clk_sys) begin
		if (req_valid) begin
			mem[wr_ptr] <= req;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (req_valid) begin
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(req_valid) - CNT_W'(pop);    // requester holds a credit
		end
	end

endmodule

// ==== hdl/port_decoder.sv ====
`timescale 1ns/100ps

module port_decoder import io_pkg::*; #(
	parameter int RESP_CREDITS = 2
) (
	input  logic     clk_sys,
	input  logic     reset,

	input  logic     q_valid,
	input  io_req_t  q_head,
	output logic     q_pop,

	input  logic     resp_credit,

	output logic     dec_valid,
	output io_req_t  dec_req,
	output dev_sel_t dec_sel,
	output logic     dec_sysctl,
	output logic     dec_wide
);

	localparam int CW = $clog2(RESP_CREDITS + 1);

	logic [CW-1:0] credits;
	logic [15:0]   addr;
	dev_sel_t      sel;

	function automatic logic port_hit(input logic [15:0] a, input port_range_t p);
		return (a >> p.ign) == (p.base >> p.ign);
	endfunction

	assign q_pop = q_valid && (credits != '0);
	assign addr  = q_head.addr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			credits <= CW'(RESP_CREDITS);
		end else begin
			case ({q_pop, resp_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// disk wins over floppy and pit over ps2 where ranges overlap
	always_comb begin
		sel        = '0;
		sel.hdd0   = port_hit(addr, PORT_HDD0) | port_hit(addr, PORT_HDD0_ALT);
		sel.hdd1   = port_hit(addr, PORT_HDD1) | port_hit(addr, PORT_HDD1_ALT);
		sel.floppy = port_hit(addr, PORT_FLOPPY) & ~sel.hdd0;
		sel.dma    = port_hit(addr, PORT_DMA_MASTER) | port_hit(addr, PORT_DMA_PAGE)
		           | port_hit(addr, PORT_DMA_SLAVE);
		sel.pic    = port_hit(addr, PORT_PIC_MASTER) | port_hit(addr, PORT_PIC_SLAVE);
		sel.pit    = port_hit(addr, PORT_PIT) | port_hit(addr, PORT_PIT_ALT);
		sel.ps2    = (port_hit(addr, PORT_PS2_IO) | port_hit(addr, PORT_PS2_CTL)) & ~sel.pit;
		sel.rtc    = port_hit(addr, PORT_RTC);
		sel.sound  = port_hit(addr, PORT_SB) | port_hit(addr, PORT_FM);
		sel.uart   = port_hit(addr, PORT_UART) | port_hit(addr, PORT_MPU);
		sel.vga    = port_hit(addr, PORT_VGA_B) | port_hit(addr, PORT_VGA_C)
		           | port_hit(addr, PORT_VGA_D);
		sel.joy    = port_hit(addr, PORT_JOY);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= q_pop;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (q_pop) begin
			dec_req    <= q_head;
			dec_sel    <= sel;
			dec_sysctl <= (addr == SYSCFG_PORT);
			dec_wide   <= ((sel.hdd0 | sel.hdd1) & ~addr[9]) | (addr == SYSCFG_PORT);    // data port
		end
	end

endmodule

// ==== hdl/syscfg_port.sv ====
`timescale 1ns/100ps

module syscfg_port import io_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,

	input  logic       dec_valid,
	input  io_req_t    dec_req,
	input  dev_sel_t   dec_sel,
	input  logic       dec_sysctl,

	output logic [7:0] syscfg
);

	logic in_reset;
	logic disk_hit;
	logic cfg_write;

	assign disk_hit  = dec_sel.hdd0 | dec_sel.hdd1 | dec_sel.floppy;
	assign cfg_write = dec_sysctl && dec_req.write && (dec_req.size == 3'd2)
	                && (dec_req.wdata.cmd.syscfg_key == SYSCFG_KEY);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			syscfg   <= SYSCFG_RESET;
			in_reset <= 1'b1;
		end else if (dec_valid) begin
			if (disk_hit && in_reset) begin
				syscfg   <= 8'h00;    // boot reached the disks
				in_reset <= 1'b0;
			end else if (cfg_write) begin
				syscfg   <= dec_req.wdata.cmd.syscfg_value;
				in_reset <= 1'b0;
			end
		end
	end

endmodule

// ==== hdl/io_resp_merge.sv ====
`timescale 1ns/100ps

module io_resp_merge import io_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,

	input  logic       dec_valid,
	input  io_req_t    dec_req,
	input  dev_sel_t   dec_sel,
	input  logic       dec_wide,
	input  dev_rdata_t dev_rdata,

	output logic       resp_valid,
	output io_resp_t   resp
);

	logic [7:0]  rdata8;
	logic [31:0] rdata;

	always_comb begin
		if (dec_sel.hdd0)        rdata8 = dev_rdata.hdd0[7:0];
		else if (dec_sel.hdd1)   rdata8 = dev_rdata.hdd1[7:0];
		else if (dec_sel.floppy) rdata8 = dev_rdata.floppy;
		else if (dec_sel.dma)    rdata8 = dev_rdata.dma;
		else if (dec_sel.pic)    rdata8 = dev_rdata.pic;
		else if (dec_sel.pit)    rdata8 = dev_rdata.pit;
		else if (dec_sel.ps2)    rdata8 = dev_rdata.ps2;
		else if (dec_sel.rtc)    rdata8 = dev_rdata.rtc;
		else if (dec_sel.sound)  rdata8 = dev_rdata.sound;
		else if (dec_sel.uart)   rdata8 = dev_rdata.uart;
		else if (dec_sel.vga)    rdata8 = dev_rdata.vga;
		else if (dec_sel.joy)    rdata8 = dev_rdata.joy;
		else                     rdata8 = UNMAPPED_BYTE;    // also sysctl
	end

	always_comb begin
		if (dec_req.write)
			rdata = 32'h0;
		else if (dec_wide && dec_sel.hdd0)
			rdata = dev_rdata.hdd0;
		else if (dec_wide && dec_sel.hdd1)
			rdata = dev_rdata.hdd1;
		else
			rdata = {24'h0, rdata8};
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= dec_valid;    // credits guarantee room downstream
		end
	end

	always_ff @(posedge clk_sys) begin
		if (dec_valid) begin
			resp.rdata <= rdata;
			resp.write <= dec_req.write;
			resp.wide  <= dec_wide;
		end
	end

endmodule

// ==== hdl/io_fabric.sv ====
`timescale 1ns/100ps

module io_fabric import io_pkg::*; #(
	parameter int QUEUE_DEPTH  = 4,
	parameter int RESP_CREDITS = 2
) (
	input  logic       clk_sys,
	input  logic       reset,

	input  logic       req_valid,
	input  io_req_t    req,
	output logic       req_credit,

	output logic       resp_valid,
	output io_resp_t   resp,
	input  logic       resp_credit,

	input  dev_rdata_t dev_rdata,
	output logic [7:0] syscfg
);

	logic     q_valid;
	io_req_t  q_head;
	logic     q_pop;
	logic     dec_valid;
	io_req_t  dec_req;
	dev_sel_t dec_sel;
	logic     dec_sysctl;
	logic     dec_wide;

	io_req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) io_req_queue_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.req_valid  (req_valid),
		.req        (req),
		.req_credit (req_credit),
		.q_valid    (q_valid),
		.q_head     (q_head),
		.q_pop      (q_pop)
	);

	port_decoder #(.RESP_CREDITS(RESP_CREDITS)) port_decoder_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.q_valid     (q_valid),
		.q_head      (q_head),
		.q_pop       (q_pop),
		.resp_credit (resp_credit),
		.dec_valid   (dec_valid),
		.dec_req     (dec_req),
		.dec_sel     (dec_sel),
		.dec_sysctl  (dec_sysctl),
		.dec_wide    (dec_wide)
	);

	syscfg_port syscfg_port_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dec_valid  (dec_valid),
		.dec_req    (dec_req),
		.dec_sel    (dec_sel),
		.dec_sysctl (dec_sysctl),
		.syscfg     (syscfg)
	);

	io_resp_merge io_resp_merge_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dec_valid  (dec_valid),
		.dec_req    (dec_req),
		.dec_sel    (dec_sel),
		.dec_wide   (dec_wide),
		.dev_rdata  (dev_rdata),
		.resp_valid (resp_valid),
		.resp       (resp)
	);

endmodule

// ==== dv/io_fabric_asserts.sv ====
`timescale 1ns/100ps

module io_fabric_asserts #(
	parameter int RESP_CREDITS = 2
) (
	input logic clk_sys,
	input logic reset,
	input logic req_valid,
	input logic q_valid,
	input logic q_pop,
	input logic req_credit,
	input logic resp_valid,
	input logic resp_credit
);

	int held;      // responses not yet credited back
	int queued;    // accepted requests not yet popped

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			held   <= 0;
			queued <= 0;
		end else begin
			held   <= held + (resp_valid ? 1 : 0) - (resp_credit ? 1 : 0);
			queued <= queued + (req_valid ? 1 : 0) - (q_pop ? 1 : 0);
		end
	end

	a_resp_within_credits: assert property (@(posedge clk_sys) disable iff (reset)
		resp_valid |-> (held < RESP_CREDITS))
		else $error("response sent without a free response credit");

	a_valid_tracks_entries: assert property (@(posedge clk_sys) disable iff (reset)
		q_valid == (queued != 0))
		else $error("queue valid does not match the number of stored requests");

	a_pop_needs_entry: assert property (@(posedge clk_sys) disable iff (reset)
		q_pop |-> (queued != 0))
		else $error("queue popped with no stored request");

	a_credit_on_pop: assert property (@(posedge clk_sys) disable iff (reset)
		req_credit == q_pop)
		else $error("request credit not returned in the cycle of the pop");

endmodule

bind io_fabric io_fabric_asserts #(.RESP_CREDITS(RESP_CREDITS)) io_fabric_asserts_i (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.req_valid   (req_valid),
	.q_valid     (q_valid),
	.q_pop       (q_pop),
	.req_credit  (req_credit),
	.resp_valid  (resp_valid),
	.resp_credit (resp_credit)
);

// ==== dv/io_fabric_tb.sv ====
`timescale 1ns/100ps

module io_fabric_tb import io_pkg::*; ();

	localparam int QUEUE_DEPTH  = 4;
	localparam int RESP_CREDITS = 2;
	localparam int MAP_SIZE     = 24;
	localparam int WAIT_LIMIT   = 500;
	localparam int RANDOM_REQS  = 400;
	localparam logic [3:0] DEV_SYSCTL = 4'd12;
	localparam logic [3:0] DEV_NONE   = 4'd13;

	typedef struct packed {
		port_range_t rng;
		logic [3:0]  dev;    // 0 hdd0 .. 11 joy, 12 sysctl
	} map_entry_t;

	// first match wins so hdd0 sits ahead of floppy and pit ahead of ps2
	map_entry_t port_map [MAP_SIZE] = '{
		'{PORT_HDD0, 4'd0}, '{PORT_HDD0_ALT, 4'd0},
		'{PORT_HDD1, 4'd1}, '{PORT_HDD1_ALT, 4'd1},
		'{PORT_FLOPPY, 4'd2},
		'{PORT_DMA_MASTER, 4'd3}, '{PORT_DMA_PAGE, 4'd3}, '{PORT_DMA_SLAVE, 4'd3},
		'{PORT_PIC_MASTER, 4'd4}, '{PORT_PIC_SLAVE, 4'd4},
		'{PORT_PIT, 4'd5}, '{PORT_PIT_ALT, 4'd5},
		'{PORT_PS2_IO, 4'd6}, '{PORT_PS2_CTL, 4'd6},
		'{PORT_RTC, 4'd7},
		'{PORT_SB, 4'd8}, '{PORT_FM, 4'd8},
		'{PORT_UART, 4'd9}, '{PORT_MPU, 4'd9},
		'{PORT_VGA_B, 4'd10}, '{PORT_VGA_C, 4'd10}, '{PORT_VGA_D, 4'd10},
		'{PORT_JOY, 4'd11},
		'{'{SYSCFG_PORT, 4'd0}, DEV_SYSCTL}
	};

	logic       clk_sys;
	logic       reset;
	logic       req_valid;
	io_req_t    req;
	logic       req_credit;
	logic       resp_valid;
	io_resp_t   resp;
	logic       resp_credit;
	dev_rdata_t dev_rdata;
	logic [7:0] syscfg;

	logic [31:0] rng_state;
	io_req_t     pending [$];    // sent and awaiting a response
	int          req_credits;
	int          held_credits;   // retired responses owed back
	int          credit_rate;    // chance out of 4 to return one
	int          sent;
	int          received;
	int          returned;
	logic [7:0]  syscfg_model;
	logic        model_in_reset;

	io_fabric #(
		.QUEUE_DEPTH  (QUEUE_DEPTH),
		.RESP_CREDITS (RESP_CREDITS)
	) io_fabric_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.req_valid   (req_valid),
		.req         (req),
		.req_credit  (req_credit),
		.resp_valid  (resp_valid),
		.resp        (resp),
		.resp_credit (resp_credit),
		.dev_rdata   (dev_rdata),
		.syscfg      (syscfg)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic dev_rdata_t random_rdata();
		dev_rdata_t d;
		d = '0;
		for (int i = 0; i < 5; i++) begin
			d = {d[111:0], next_random()};
		end
		return d;
	endfunction

	function automatic logic [3:0] lookup_dev(input logic [15:0] addr);
		logic [15:0] mask;
		for (int i = 0; i < MAP_SIZE; i++) begin
			mask = 16'hFFFF << port_map[i].rng.ign;
			if ((addr & mask) == port_map[i].rng.base)
				return port_map[i].dev;
		end
		return DEV_NONE;
	endfunction

	function automatic logic [7:0] dev_byte(input logic [3:0] dev, input dev_rdata_t d);
		case (dev)
			4'd0:    return d.hdd0[7:0];
			4'd1:    return d.hdd1[7:0];
			4'd2:    return d.floppy;
			4'd3:    return d.dma;
			4'd4:    return d.pic;
			4'd5:    return d.pit;
			4'd6:    return d.ps2;
			4'd7:    return d.rtc;
			4'd8:    return d.sound;
			4'd9:    return d.uart;
			4'd10:   return d.vga;
			4'd11:   return d.joy;
			default: return UNMAPPED_BYTE;    // unmapped and sysctl
		endcase
	endfunction

	function automatic io_req_t make_req(input logic [15:0] addr, input logic write,
			input io_size_t size, input logic [31:0] data);
		io_req_t r;
		r.addr      = addr;
		r.write     = write;
		r.size      = size;
		r.wdata.raw = data;
		return r;
	endfunction

	function automatic io_req_t random_req();
		io_req_t     r;
		map_entry_t  m;
		logic [15:0] span;
		r.wdata.raw = next_random();
		if (next_random() % 2 == 0) begin
			m      = port_map[next_random() % MAP_SIZE];
			span   = (16'h1 << m.rng.ign) - 16'h1;
			r.addr = m.rng.base | (16'(next_random()) & span);
		end else begin
			r.addr = 16'(next_random());
		end
		r.write = 1'(next_random());
		case (next_random() % 3)
			0:       r.size = 3'd1;
			1:       r.size = 3'd2;
			default: r.size = 3'd4;
		endcase
		if (1'(next_random()))
			r.wdata.cmd.syscfg_key = SYSCFG_KEY;    // make config writes likely
		return r;
	endfunction

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic predict(input io_req_t r, output io_resp_t e);
		logic [3:0] dev;
		logic       disk;
		dev     = lookup_dev(r.addr);
		disk    = (dev <= 4'd2);
		e.write = r.write;
		e.wide  = ((dev <= 4'd1) && !r.addr[9]) || (dev == DEV_SYSCTL);
		if (r.write)
			e.rdata = '0;
		else if (e.wide && dev == 4'd0)
			e.rdata = dev_rdata.hdd0;
		else if (e.wide && dev == 4'd1)
			e.rdata = dev_rdata.hdd1;
		else
			e.rdata = {24'h0, dev_byte(dev, dev_rdata)};
		if (disk && model_in_reset) begin
			syscfg_model   = 8'h00;
			model_in_reset = 1'b0;
		end else if (dev == DEV_SYSCTL && r.write && r.size == 3'd2
				&& r.wdata.cmd.syscfg_key == SYSCFG_KEY) begin
			syscfg_model   = r.wdata.cmd.syscfg_value;
			model_in_reset = 1'b0;
		end
	endtask

	task automatic check_response();
		io_req_t  r;
		io_resp_t e;
		assert (pending.size() != 0)
			else stop_on_error("a response came out with no request outstanding");
		r = pending.pop_front();
		predict(r, e);
		assert (resp === e)
			else stop_on_error($sformatf("mismatch at %0t: resp expected %h, got %h",
				$time, e, resp));
		received++;
		held_credits++;
	endtask

	// one cycle of sampling outputs and then driving the next inputs
	task automatic step();
		@(negedge clk_sys);
		if (req_credit) begin
			req_credits++;
			returned++;
		end
		if (resp_valid)
			check_response();
		assert (syscfg === syscfg_model)
			else stop_on_error($sformatf("mismatch at %0t: syscfg expected %h, got %h",
				$time, syscfg_model, syscfg));
		req_valid   = 1'b0;
		resp_credit = 1'b0;
		if (held_credits > 0 && int'(next_random() % 4) < credit_rate) begin
			resp_credit = 1'b1;
			held_credits--;
		end
		if (sent == received)
			dev_rdata = random_rdata();    // nothing in flight
	endtask

	task automatic send(input io_req_t r);
		int waited;
		step();
		waited = 0;
		while (req_credits == 0) begin
			assert (waited < WAIT_LIMIT)
				else stop_on_error("timed out waiting for a request credit");
			step();
			waited++;
		end
		req_valid = 1'b1;
		req       = r;
		req_credits--;
		sent++;
		pending.push_back(r);
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (received < sent || held_credits > 0 || req_credits < QUEUE_DEPTH) begin
			assert (waited < WAIT_LIMIT)
				else stop_on_error("timed out waiting for outstanding responses");
			step();
			waited++;
		end
	endtask

	initial begin
		logic [15:0] top_addr;
		rng_state      = 32'hddea8dfe;
		reset          = 1'b1;
		req_valid      = 1'b0;
		req            = '0;
		resp_credit    = 1'b0;
		dev_rdata      = random_rdata();
		req_credits    = QUEUE_DEPTH;
		held_credits   = 0;
		credit_rate    = 4;
		sent           = 0;
		received       = 0;
		returned       = 0;
		syscfg_model   = SYSCFG_RESET;
		model_in_reset = 1'b1;
		repeat (3) @(negedge clk_sys);
		reset = 1'b0;

		repeat (8) step();    // idle with syscfg at reset value

		send(make_req(16'h0060, 1'b0, 3'd1, 32'h0));
		send(make_req(16'h03F2, 1'b0, 3'd1, 32'h0));    // floppy clears syscfg
		send(make_req(SYSCFG_PORT, 1'b1, 3'd2, 32'h0000_A15A));
		send(make_req(SYSCFG_PORT, 1'b1, 3'd1, 32'h0000_A133));
		send(make_req(SYSCFG_PORT, 1'b1, 3'd2, 32'h0000_7744));
		send(make_req(16'h01F4, 1'b0, 3'd4, 32'h0));    // no second clear
		send(make_req(SYSCFG_PORT, 1'b0, 3'd2, 32'h0));
		drain();

		for (int i = 0; i < MAP_SIZE; i++) begin
			top_addr = port_map[i].rng.base | ((16'h1 << port_map[i].rng.ign) - 16'h1);
			send(make_req(port_map[i].rng.base, 1'b0, 3'd1, 32'h0));
			send(make_req(top_addr, 1'b0, 3'd4, 32'h0));
		end
		drain();

		for (int n = 0; n < RANDOM_REQS; n++) begin
			credit_rate = ((n / 50) % 2 == 0) ? 1 : 3;    // alternate starved stretches
			repeat (next_random() % 3) step();
			send(random_req());
		end
		credit_rate = 4;
		drain();
		repeat (8) step();

		assert (returned == sent)
			else stop_on_error($sformatf("mismatch at %0t: req_credit count expected %0d, got %0d",
				$time, sent, returned));
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== compile.f ====
hdl/io_pkg.sv
hdl/io_req_queue.sv
hdl/port_decoder.sv
hdl/syscfg_port.sv
hdl/io_resp_merge.sv
hdl/io_fabric.sv
dv/io_fabric_asserts.sv
dv/io_fabric_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the io_fabric testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module io_fabric_tb \
	-f compile.f

./obj_dir/Vio_fabric_tb 2>&1 | tee sim.log

if grep -q "^TESTBENCH PASSED$" sim.log; then
	echo "run.sh: simulation passed"
	exit 0
else
	echo "run.sh: simulation did not pass, see sim.log"
	exit 1
fi
